// ==== quarkCore_cfg.svh ====
//******************
// Core-wide widths, register count and reset address
//******************

`ifndef QUARK_CORE_CFG_SVH
`define QUARK_CORE_CFG_SVH

// Data and address word width
`define QUARK_XLEN 32

// Number of architectural registers
`define QUARK_NREGS 32

// Register index width
`define QUARK_REGIDX 5

// First instruction fetch address
`define QUARK_RESET_ADDR 32'h0000_0000

`endif

// ==== quarkPkg.sv ====
//******************
// Latched instruction word type with its two format views
//******************

`default_nettype none

`include "quarkCore_cfg.svh"

package quarkPkg;

   // Instruction bits 31:2, bits 1:0 are always 2'b11 in RV32I and are dropped
   // Register format view and store format view of the same 30 bits
   typedef union packed {
      // R-type layout, also used for I, U and J fields
      struct packed {
         logic [6:0]               funct7;
         logic [`QUARK_REGIDX-1:0] rs2;
         logic [`QUARK_REGIDX-1:0] rs1;
         logic [2:0]               funct3;
         logic [`QUARK_REGIDX-1:0] rd;
         logic [4:0]               opcode;
      } rFields;
      // S-type layout, the rd slot holds the low immediate bits
      struct packed {
         logic [6:0]               immHi;
         logic [`QUARK_REGIDX-1:0] rs2;
         logic [`QUARK_REGIDX-1:0] rs1;
         logic [2:0]               funct3;
         logic [4:0]               immLo;
         logic [4:0]               opcode;
      } sFields;
   } instrWord_u;

endpackage

`default_nettype wire

// ==== quarkDecoder.sv ====
//******************
// Opcode class decode and immediate formats
//******************

`timescale 1ns/1ps
`default_nettype none

`include "quarkCore_cfg.svh"

module quarkDecoder import quarkPkg::*; (
   input  instrWord_u              instr,
   output logic                    isLoad,
   output logic                    isStore,
   output logic                    isAluImm,
   output logic                    isAluReg,
   output logic                    isAuipc,
   output logic                    isLui,
   output logic                    isBranch,
   output logic                    isJal,
   output logic                    isJalr,
   output logic [`QUARK_XLEN-1:0]  immI,
   output logic [`QUARK_XLEN-1:0]  immS,
   output logic [`QUARK_XLEN-1:0]  immB,
   output logic [`QUARK_XLEN-1:0]  immU,
   output logic [`QUARK_XLEN-1:0]  immJ
);

   // Opcode bits 6:2 of the nine kept classes
   localparam logic [4:0] opLoad   = 5'b00000;
   localparam logic [4:0] opAluImm = 5'b00100;
   localparam logic [4:0] opAuipc  = 5'b00101;
   localparam logic [4:0] opStore  = 5'b01000;
   localparam logic [4:0] opAluReg = 5'b01100;
   localparam logic [4:0] opLui    = 5'b01101;
   localparam logic [4:0] opBranch = 5'b11000;
   localparam logic [4:0] opJalr   = 5'b11001;
   localparam logic [4:0] opJal    = 5'b11011;

   // SYSTEM and unknown opcodes fall through with no class set
   assign isLoad   = (instr.rFields.opcode == opLoad);
   assign isAluImm = (instr.rFields.opcode == opAluImm);
   assign isAuipc  = (instr.rFields.opcode == opAuipc);
   assign isStore  = (instr.rFields.opcode == opStore);
   assign isAluReg = (instr.rFields.opcode == opAluReg);
   assign isLui    = (instr.rFields.opcode == opLui);
   assign isBranch = (instr.rFields.opcode == opBranch);
   assign isJalr   = (instr.rFields.opcode == opJalr);
   assign isJal    = (instr.rFields.opcode == opJal);

   // I-type, sign bit is funct7 msb
   assign immI = {{21{instr.rFields.funct7[6]}}, instr.rFields.funct7[5:0], instr.rFields.rs2};
   // S-type, split around rs1/rs2
   assign immS = {{21{instr.sFields.immHi[6]}}, instr.sFields.immHi[5:0],
                  instr.sFields.immLo};
   // B-type, bit 11 sits in the low immediate slot
   assign immB = {{20{instr.sFields.immHi[6]}}, instr.sFields.immLo[0],
                  instr.sFields.immHi[5:0], instr.sFields.immLo[4:1], 1'b0};
   // U-type, upper 20 bits
   assign immU = {instr.rFields.funct7, instr.rFields.rs2, instr.rFields.rs1,
                  instr.rFields.funct3, 12'b0};
   // J-type, scrambled 20-bit offset
   assign immJ = {{12{instr.rFields.funct7[6]}}, instr.rFields.rs1, instr.rFields.funct3,
                  instr.rFields.rs2[0], instr.rFields.funct7[5:0],
                  instr.rFields.rs2[4:1], 1'b0};

endmodule

`default_nettype wire

// ==== quarkRegFile.sv ====
//******************
// 32-entry register file
//******************

`timescale 1ns/1ps
`default_nettype none

`include "quarkCore_cfg.svh"

module quarkRegFile (
   input  logic                     clk,
   input  logic                     readEn,
   input  logic [`QUARK_REGIDX-1:0] rs1Idx,
   input  logic [`QUARK_REGIDX-1:0] rs2Idx,
   input  logic                     writeEn,
   input  logic [`QUARK_REGIDX-1:0] rdId,
   input  logic [`QUARK_XLEN-1:0]   wbData,
   output logic [`QUARK_XLEN-1:0]   rs1Val,
   output logic [`QUARK_XLEN-1:0]   rs2Val
);

   logic [`QUARK_XLEN-1:0] regs [`QUARK_NREGS];

   // All registers start at zero, x0 is never written afterwards
   initial begin
      for (int i = 0; i < `QUARK_NREGS; i++) begin
         regs[i] = '0;
      end
   end

   // Write port, x0 stays hard-wired to zero
   always_ff @(posedge clk) begin
      if (writeEn && (rdId != '0)) begin
         regs[rdId] <= wbData;
      end
   end

   // Operands captured as the instruction word arrives
   always_ff @(posedge clk) begin
      if (readEn) begin
         rs1Val <= regs[rs1Idx];
         rs2Val <= regs[rs2Idx];
      end
   end

   // Any read of x0 returns zero on the next cycle
   assert property (@(posedge clk) readEn |=>
      (($past(rs1Idx) != '0) || (rs1Val == '0)) &&
      (($past(rs2Idx) != '0) || (rs2Val == '0)));

endmodule

`default_nettype wire

// ==== quarkAlu.sv ====
//******************
// Shared adder, comparator, shifter, result select
// and branch decision
//******************

`timescale 1ns/1ps
`default_nettype none

`include "quarkCore_cfg.svh"

module quarkAlu import quarkPkg::*; (
   input  instrWord_u             instr,
   input  logic                   isLoad,
   input  logic                   isStore,
   input  logic                   isAluImm,
   input  logic                   isAluReg,
   input  logic                   isAuipc,
   input  logic                   isBranch,
   input  logic                   isJal,
   input  logic                   isJalr,
   input  logic [`QUARK_XLEN-1:0] immI,
   input  logic [`QUARK_XLEN-1:0] immS,
   input  logic [`QUARK_XLEN-1:0] immB,
   input  logic [`QUARK_XLEN-1:0] immU,
   input  logic [`QUARK_XLEN-1:0] immJ,
   input  logic [`QUARK_XLEN-1:0] pc,
   input  logic [`QUARK_XLEN-1:0] rs1Val,
   input  logic [`QUARK_XLEN-1:0] rs2Val,
   output logic [`QUARK_XLEN-1:0] aluPlus,
   output logic [`QUARK_XLEN-1:0] aluOut,
   output logic                   takeBranch
);

   logic                   isAlu;
   logic [7:0]             funct3Is;
   logic [`QUARK_XLEN-1:0] aluIn1;
   logic [`QUARK_XLEN-1:0] aluIn2;
   logic [`QUARK_XLEN-1:0] plusIn1;
   logic [`QUARK_XLEN-1:0] plusIn2;
   logic [`QUARK_XLEN:0]   aluMinus;
   logic                   lt;
   logic                   ltu;
   logic                   eq;
   logic [`QUARK_XLEN-1:0] shifterIn;
   logic [`QUARK_XLEN:0]   shiftFull;
   logic [`QUARK_XLEN-1:0] shifted;
   logic [`QUARK_XLEN-1:0] leftShift;
   logic                   isSub;
   logic                   predicate;

   // Mirror a word end to end
   function automatic logic [`QUARK_XLEN-1:0] bitRev(input logic [`QUARK_XLEN-1:0] v);
      logic [`QUARK_XLEN-1:0] r;
      for (int i = 0; i < `QUARK_XLEN; i++) begin
         r[i] = v[`QUARK_XLEN-1-i];
      end
      return r;
   endfunction

   assign isAlu = isAluImm | isAluReg;

   // One-hot funct3
   assign funct3Is = 8'b0000_0001 << instr.rFields.funct3;

   // Operand B is rs2 for register ops and branches, else the I immediate
   assign aluIn1 = rs1Val;
   assign aluIn2 = (isAluReg | isBranch) ? rs2Val : immI;

   // Shared adder, also the address and jump target generator
   assign plusIn1 = (isAlu | isStore | isLoad | isJalr) ? rs1Val : pc;
   assign plusIn2 = isStore  ? immS :
                    isJal    ? immJ :
                    isAuipc  ? immU :
                    isBranch ? immB :
                    isAluReg ? rs2Val : immI;
   assign aluPlus = plusIn1 + plusIn2;

   // 33-bit subtract, borrow gives unsigned less-than
   assign aluMinus = {1'b0, aluIn1} - {1'b0, aluIn2};
   // Signs differ, so rs1 sign decides
   assign lt  = (aluIn1[`QUARK_XLEN-1] ^ aluIn2[`QUARK_XLEN-1]) ?
                aluIn1[`QUARK_XLEN-1] : aluMinus[`QUARK_XLEN];
   assign ltu = aluMinus[`QUARK_XLEN];
   assign eq  = (aluMinus[`QUARK_XLEN-1:0] == '0);

   // Left shift as a right shift of the reversed word
   assign shifterIn = funct3Is[1] ? bitRev(aluIn1) : aluIn1;
   // Extra msb carries the sign only for SRA/SRAI
   assign shiftFull = $signed({instr.rFields.funct7[5] & aluIn1[`QUARK_XLEN-1], shifterIn})
                      >>> aluIn2[4:0];
   assign shifted   = shiftFull[`QUARK_XLEN-1:0];
   assign leftShift = bitRev(shifted);

   // funct7 bit 5 means SUB only for the register form, ADDI reuses it as imm
   assign isSub = isAluReg & instr.rFields.funct7[5];

   assign aluOut =
      (funct3Is[0] ? (isSub ? aluMinus[`QUARK_XLEN-1:0] : aluPlus) : '0) |
      (funct3Is[1] ? leftShift                                      : '0) |
      (funct3Is[2] ? {{(`QUARK_XLEN-1){1'b0}}, lt}                 : '0) |
      (funct3Is[3] ? {{(`QUARK_XLEN-1){1'b0}}, ltu}                : '0) |
      (funct3Is[4] ? aluIn1 ^ aluIn2                                : '0) |
      (funct3Is[5] ? shifted                                        : '0) |
      (funct3Is[6] ? aluIn1 | aluIn2                                : '0) |
      (funct3Is[7] ? aluIn1 & aluIn2                                : '0);

   // BEQ, BNE, BLT, BGE, BLTU, BGEU
   assign predicate = (funct3Is[0] &  eq)  |
                      (funct3Is[1] & ~eq)  |
                      (funct3Is[4] &  lt)  |
                      (funct3Is[5] & ~lt)  |
                      (funct3Is[6] &  ltu) |
                      (funct3Is[7] & ~ltu);

   // Jumps always redirect
   assign takeBranch = isJal | isJalr | (isBranch & predicate);

endmodule

`default_nettype wire

// ==== quarkSequencer.sv ====
//******************
// One-hot FSM, PC, instruction latch, memory
// address select and write-back select
//******************

`timescale 1ns/1ps
`default_nettype none

`include "quarkCore_cfg.svh"

module quarkSequencer import quarkPkg::*; (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic [`QUARK_XLEN-1:0]   memRdata,
   input  logic                     memRbusy,
   input  logic                     memWbusy,
   output logic [`QUARK_XLEN-1:0]   memAddr,
   output logic                     memRstrb,
   output logic                     memWstrb,
   output instrWord_u               instr,
   output logic [`QUARK_XLEN-1:0]   pc,
   output logic                     readEn,
   output logic                     writeEn,
   output logic [`QUARK_REGIDX-1:0] rs1Idx,
   output logic [`QUARK_REGIDX-1:0] rs2Idx,
   output logic [`QUARK_REGIDX-1:0] rdId,
   output logic [`QUARK_XLEN-1:0]   wbData,
   input  logic                     isLoad,
   input  logic                     isStore,
   input  logic                     isBranch,
   input  logic                     isJal,
   input  logic                     isJalr,
   input  logic                     isLui,
   input  logic                     isAuipc,
   input  logic                     isAluImm,
   input  logic                     isAluReg,
   input  logic [`QUARK_XLEN-1:0]   immU,
   input  logic [`QUARK_XLEN-1:0]   aluPlus,
   input  logic [`QUARK_XLEN-1:0]   aluOut,
   input  logic                     takeBranch
);

   // State bit positions
   localparam int fetchInstrBit   = 0;
   localparam int waitInstrBit    = 1;
   localparam int executeBit      = 2;
   localparam int waitAluOrMemBit = 3;

   localparam logic [3:0] fetchInstr   = 4'b1 << fetchInstrBit;
   localparam logic [3:0] waitInstr    = 4'b1 << waitInstrBit;
   localparam logic [3:0] execute      = 4'b1 << executeBit;
   localparam logic [3:0] waitAluOrMem = 4'b1 << waitAluOrMemBit;

   logic [3:0]             state;
   logic [`QUARK_XLEN-1:0] pcPlus4;
   logic [`QUARK_XLEN-1:0] pcNew;
   logic                   isMem;
   logic                   validOp;

   assign isMem   = isLoad | isStore;
   assign validOp = isLoad | isStore | isAluImm | isAluReg | isAuipc | isLui |
                    isBranch | isJal | isJalr;

   // Next PC, jump targets forced to even
   assign pcPlus4 = pc + 32'd4;
   assign pcNew   = takeBranch ? {aluPlus[`QUARK_XLEN-1:1], 1'b0} : pcPlus4;

   // PC while fetching, next PC in execute, data address otherwise
   assign memAddr = (state[fetchInstrBit] | state[waitInstrBit]) ? pc :
                    (state[executeBit] & ~isMem)                 ? pcNew : aluPlus;

   // Execute strobe is the next fetch, or the load itself
   assign memRstrb = (state[executeBit] & ~isStore) | state[fetchInstrBit];
   assign memWstrb = state[executeBit] & isStore;

   // Register reads use the word as it arrives on the bus
   assign readEn = state[waitInstrBit] & ~memRbusy;
   assign rs1Idx = memRdata[19:15];
   assign rs2Idx = memRdata[24:20];
   assign rdId   = instr.rFields.rd;

   // Unknown opcodes, branches and stores leave the register file alone
   // Load data lands during the memory wait
   assign writeEn = validOp & ~(isBranch | isStore) &
                    ((state[executeBit] & ~isLoad) | state[waitAluOrMemBit]);

   assign wbData = (isLui               ? immU     : '0) |
                   (isAluImm | isAluReg ? aluOut   : '0) |
                   (isAuipc             ? aluPlus  : '0) |
                   (isJal | isJalr      ? pcPlus4  : '0) |
                   (isLoad              ? memRdata : '0);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         // Park until memory is idle, then fetch
         state <= waitAluOrMem;
         pc    <= `QUARK_RESET_ADDR;
         // Invalid opcode, rd of x0
         instr <= 30'd1;
      end else begin
         case (1'b1)
            state[waitInstrBit]: begin
               if (!memRbusy) begin
                  instr <= memRdata[`QUARK_XLEN-1:2];
                  state <= execute;
               end
            end
            state[executeBit]: begin
               pc    <= pcNew;
               state <= isMem ? waitAluOrMem : waitInstr;
            end
            state[waitAluOrMemBit]: begin
               if (!memRbusy && !memWbusy) begin
                  state <= fetchInstr;
               end
            end
            // fetchInstr
            default: begin
               state <= waitInstr;
            end
         endcase
      end
   end

   // Exactly one state active out of reset
   assert property (@(posedge clk) disable iff (!resetn) $onehot(state));

   // Read and write never start together
   assert property (@(posedge clk) disable iff (!resetn) !(memRstrb && memWstrb));

endmodule

`default_nettype wire

// ==== quarkCore.sv ====
//******************
// Quark RV32I core top level
//******************

`timescale 1ns/1ps
`default_nettype none

`include "quarkCore_cfg.svh"

module quarkCore import quarkPkg::*; (
   input  logic                   clk,
   input  logic                   resetn,
   output logic [`QUARK_XLEN-1:0] memAddr,
   output logic [`QUARK_XLEN-1:0] memWdata,
   output logic                   memRstrb,
   output logic                   memWstrb,
   input  logic [`QUARK_XLEN-1:0] memRdata,
   input  logic                   memRbusy,
   input  logic                   memWbusy
);

   // Latched instruction and PC
   instrWord_u             instr;
   logic [`QUARK_XLEN-1:0] pc;

   // Decoded classes
   logic isLoad;
   logic isStore;
   logic isAluImm;
   logic isAluReg;
   logic isAuipc;
   logic isLui;
   logic isBranch;
   logic isJal;
   logic isJalr;

   // Immediates
   logic [`QUARK_XLEN-1:0] immI;
   logic [`QUARK_XLEN-1:0] immS;
   logic [`QUARK_XLEN-1:0] immB;
   logic [`QUARK_XLEN-1:0] immU;
   logic [`QUARK_XLEN-1:0] immJ;

   // Register file ports
   logic                     readEn;
   logic                     writeEn;
   logic [`QUARK_REGIDX-1:0] rs1Idx;
   logic [`QUARK_REGIDX-1:0] rs2Idx;
   logic [`QUARK_REGIDX-1:0] rdId;
   logic [`QUARK_XLEN-1:0]   wbData;
   logic [`QUARK_XLEN-1:0]   rs1Val;
   logic [`QUARK_XLEN-1:0]   rs2Val;

   // ALU results
   logic [`QUARK_XLEN-1:0] aluPlus;
   logic [`QUARK_XLEN-1:0] aluOut;
   logic                   takeBranch;

   // Stores always write the full rs2 word
   assign memWdata = rs2Val;

   quarkSequencer uSequencer (
      .clk(clk), .resetn(resetn),
      .memRdata(memRdata), .memRbusy(memRbusy), .memWbusy(memWbusy),
      .memAddr(memAddr), .memRstrb(memRstrb), .memWstrb(memWstrb),
      .instr(instr), .pc(pc), .readEn(readEn), .writeEn(writeEn),
      .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rdId(rdId), .wbData(wbData),
      .isLoad(isLoad), .isStore(isStore), .isBranch(isBranch), .isJal(isJal),
      .isJalr(isJalr), .isLui(isLui), .isAuipc(isAuipc), .isAluImm(isAluImm),
      .isAluReg(isAluReg), .immU(immU),
      .aluPlus(aluPlus), .aluOut(aluOut), .takeBranch(takeBranch)
   );

   quarkDecoder uDecoder (
      .instr(instr),
      .isLoad(isLoad), .isStore(isStore), .isAluImm(isAluImm), .isAluReg(isAluReg),
      .isAuipc(isAuipc), .isLui(isLui), .isBranch(isBranch), .isJal(isJal),
      .isJalr(isJalr),
      .immI(immI), .immS(immS), .immB(immB), .immU(immU), .immJ(immJ)
   );

   quarkRegFile uRegFile (
      .clk(clk), .readEn(readEn), .rs1Idx(rs1Idx), .rs2Idx(rs2Idx),
      .writeEn(writeEn), .rdId(rdId), .wbData(wbData),
      .rs1Val(rs1Val), .rs2Val(rs2Val)
   );

   quarkAlu uAlu (
      .instr(instr),
      .isLoad(isLoad), .isStore(isStore), .isAluImm(isAluImm), .isAluReg(isAluReg),
      .isAuipc(isAuipc), .isBranch(isBranch), .isJal(isJal), .isJalr(isJalr),
      .immI(immI), .immS(immS), .immB(immB), .immU(immU), .immJ(immJ),
      .pc(pc), .rs1Val(rs1Val), .rs2Val(rs2Val),
      .aluPlus(aluPlus), .aluOut(aluOut), .takeBranch(takeBranch)
   );

endmodule

`default_nettype wire

// ==== tbQuarkCore.sv ====
//********************
// Testbench for the Quark core with clock, reset and a memory model
// with random busy, the cases-file loader and store checks
//********************

`timescale 1ns/1ps
`default_nettype none

`include "quarkCore_cfg.svh"

module tbQuarkCore;

   // 1 KiB of word-addressed memory
   localparam int memWords = 256;

   logic                   clk      = 1'b0;
   logic                   resetn   = 1'b0;
   logic [`QUARK_XLEN-1:0] memAddr;
   logic [`QUARK_XLEN-1:0] memWdata;
   logic                   memRstrb;
   logic                   memWstrb;
   logic [`QUARK_XLEN-1:0] memRdata = '0;
   logic                   memRbusy = 1'b0;
   logic                   memWbusy = 1'b0;

   logic [`QUARK_XLEN-1:0] mem [memWords];
   // Expected store sequence
   logic [`QUARK_XLEN-1:0] expAddrQ [$];
   logic [`QUARK_XLEN-1:0] expDataQ [$];
   logic [`QUARK_XLEN-1:0] discardWord;
   // Read word held back while busy
   logic [`QUARK_XLEN-1:0] rdHeld    = '0;
   int unsigned            rdCount   = 0;
   int unsigned            wrCount   = 0;
   int unsigned            busyDraw;
   int unsigned            seedInit;
   logic                   fetchSeen = 1'b0;
   int                     progCount = 0;
   int                     cycleCount = 0;
   int                     cycleLimit;

   quarkCore UUT (
      .clk(clk), .resetn(resetn),
      .memAddr(memAddr), .memWdata(memWdata),
      .memRstrb(memRstrb), .memWstrb(memWstrb),
      .memRdata(memRdata), .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   // 100 ns clock
   always #50 clk = ~clk;

   task automatic stopOnFailure();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic checkAddr(input logic [`QUARK_XLEN-1:0] got,
                            input logic [`QUARK_XLEN-1:0] expected, input string what);
      if (got !== expected) begin
         $display("** Error at %0t ns: %s address 0x%08h, expected 0x%08h",
                  $time, what, got, expected);
         stopOnFailure();
      end
   endtask

   task automatic checkData(input logic [`QUARK_XLEN-1:0] got,
                            input logic [`QUARK_XLEN-1:0] expected, input string what);
      if (got !== expected) begin
         $display("** Error at %0t ns: %s data 0x%08h, expected 0x%08h",
                  $time, what, got, expected);
         stopOnFailure();
      end
   endtask

   // P lines fill memory and E lines queue the expected stores
   task automatic loadCases();
      int                     fd;
      int                     rc;
      string                  line;
      logic [`QUARK_XLEN-1:0] addrVal;
      logic [`QUARK_XLEN-1:0] dataVal;
      // Fill so that any stray fetch or load shows its own index
      for (int i = 0; i < memWords; i++) begin
         mem[i] = 32'hA55A_0000 | i;
      end
      fd = $fopen("quarkCore_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open quarkCore_cases.txt");
         stopOnFailure();
      end
      while (!$feof(fd)) begin
         line = "";
         rc = $fgets(line, fd);
         // Comment and blank lines start with anything else
         if (rc > 0 && (line[0] == "P" || line[0] == "E")) begin
            rc = $sscanf(line.substr(1, line.len() - 1), "%h %h", addrVal, dataVal);
            if (rc != 2) begin
               $display("Cases file has a malformed line: %s", line);
               stopOnFailure();
            end
            if (line[0] == "P") begin
               if (addrVal >= memWords) begin
                  $display("Program word address %0h lies outside memory", addrVal);
                  stopOnFailure();
               end
               mem[addrVal] = dataVal;
               progCount++;
            end else begin
               expAddrQ.push_back(addrVal);
               expDataQ.push_back(dataVal);
            end
         end
      end
      $fclose(fd);
      if (expAddrQ.size() == 0) begin
         $display("Cases file holds no expected stores");
         stopOnFailure();
      end
   endtask

   // Memory model sees the core outputs from before the edge
   always @(posedge clk) begin
      if (!resetn) begin
         if ((memRstrb === 1'b1) || (memWstrb === 1'b1)) begin
            $display("A memory strobe was raised while reset was held");
            stopOnFailure();
         end
         memRbusy <= 1'b0;
         memWbusy <= 1'b0;
         rdCount  <= 0;
         wrCount  <= 0;
      end else begin
         // Read port scrambles the data until busy drops
         if (memRstrb === 1'b1) begin
            if (!fetchSeen) begin
               checkAddr(memAddr, `QUARK_RESET_ADDR, "First fetch");
               fetchSeen <= 1'b1;
            end
            busyDraw = $urandom % 4;
            rdHeld   <= mem[memAddr[9:2]];
            rdCount  <= busyDraw;
            memRbusy <= (busyDraw != 0);
            memRdata <= (busyDraw != 0) ? $urandom : mem[memAddr[9:2]];
         end else if (rdCount != 0) begin
            rdCount  <= rdCount - 1;
            memRbusy <= (rdCount != 1);
            memRdata <= (rdCount != 1) ? $urandom : rdHeld;
         end
         // Write port matches each store against the queue head
         if (memWstrb === 1'b1) begin
            if (expAddrQ.size() == 0) begin
               $display("Unexpected store to 0x%08h after the last expected one", memAddr);
               stopOnFailure();
            end
            checkAddr(memAddr, expAddrQ[0], "Store");
            checkData(memWdata, expDataQ[0], "Store");
            discardWord = expAddrQ.pop_front();
            discardWord = expDataQ.pop_front();
            mem[memAddr[9:2]] <= memWdata;
            busyDraw = $urandom % 4;
            wrCount  <= busyDraw;
            memWbusy <= (busyDraw != 0);
         end else if (wrCount != 0) begin
            wrCount  <= wrCount - 1;
            memWbusy <= (wrCount != 1);
         end
      end
   end

   initial begin
      seedInit = $urandom(32'h1627);
      loadCases();
      // Worst case is about 10 cycles per instruction with full busy
      cycleLimit = progCount * 10 + 100;
      repeat (4) @(posedge clk);
      resetn <= 1'b1;
      // Count cycles until the last expected store has been seen
      while (expAddrQ.size() != 0 && cycleCount < cycleLimit) begin
         @(negedge clk);
         cycleCount++;
      end
      if (expAddrQ.size() == 0) begin
         $display("Simulation passed");
         $finish;
      end else begin
         $display("Program did not finish within %0d cycles, %0d stores missing",
                  cycleLimit, expAddrQ.size());
         stopOnFailure();
      end
   end

endmodule

`default_nettype wire

// ==== quarkCore.f ====
+incdir+.
quarkPkg.sv
quarkDecoder.sv
quarkRegFile.sv
quarkAlu.sv
quarkSequencer.sv
quarkCore.sv
tbQuarkCore.sv

// ==== Bender.yml ====
package:
  name: quarkCore

export_include_dirs:
  - .

sources:
  - quarkPkg.sv
  - quarkDecoder.sv
  - quarkRegFile.sv
  - quarkAlu.sv
  - quarkSequencer.sv
  - quarkCore.sv
  - target: test
    files:
      - tbQuarkCore.sv

// ==== quarkCore_cases.txt ====
# P <word address> <instruction word>, program image in hex
# E <byte address> <data>, expected stores in order, hex
P 00 06400093
P 01 FDB00113
P 02 002082B3
P 03 30502023
P 04 402082B3
P 05 30502223
P 06 0020C2B3
P 07 30502423
P 08 0020E2B3
P 09 30502623
P 0A 0020F2B3
P 0B 30502823
P 0C 123452B7
P 0D 30502A23
P 0E 00001297
P 0F 30502C23
P 10 30202E23
P 11 00400313
P 12 006112B3
P 13 32502023
P 14 006152B3
P 15 32502223
P 16 406152B3
P 17 32502423
P 18 001122B3
P 19 32502623
P 1A 001132B3
P 1B 32502823
P 1C FFB00193
P 1D 00700213
# Branch pairs, taken ones skip an ORI into x10, not taken ones run an ORI into x11
P 1E 00420463
P 1F 00156513
P 20 00418463
P 21 0015E593
P 22 00419463
P 23 00256513
P 24 00421463
P 25 0025E593
P 26 0041C463
P 27 00456513
P 28 00324463
P 29 0045E593
P 2A 00325463
P 2B 00856513
P 2C 0041D463
P 2D 0085E593
P 2E 00326463
P 2F 01056513
P 30 0041E463
P 31 0105E593
P 32 0041F463
P 33 02056513
P 34 00327463
P 35 0205E593
P 36 32A02A23
P 37 32B02C23
# Jumps skip a write to their own link register
P 38 008003EF
P 39 05500393
P 3A 32702E23
P 3B 0F4004E7
P 3C 05500493
P 3D 34902023
P 3E 30002603
P 3F 34C02223
P 40 06300013
P 41 34002423
P 42 0000006F
# ADD SUB XOR OR AND LUI AUIPC ADDI
E 300 0000003F
E 304 00000089
E 308 FFFFFFBF
E 30C FFFFFFFF
E 310 00000040
E 314 12345000
E 318 00001038
E 31C FFFFFFDB
# SLL SRL SRA SLT SLTU
E 320 FFFFFDB0
E 324 0FFFFFFD
E 328 FFFFFFFD
E 32C 00000001
E 330 00000000
# Branch marks, JAL and JALR links, load copy, x0
E 334 00000000
E 338 0000003F
E 33C 000000E4
E 340 000000F0
E 344 0000003F
E 348 00000000
